/* beat_counter.sv */
// Narrow beat and lane tracking for one burst
// Loaded by the burst FSM, stepped on every narrow beat taken

`default_nettype none

module beat_counter
    import rd_pkg::*;
(
    input  wire logic       aclk,
    input  wire logic       rst_n,
    input  wire logic       load,
    input  wire lane_t      start_lane,
    input  wire logic [7:0] narrow_len,
    input  wire logic       beat_taken,
    output lane_t           lane,
    output logic            lane_end,
    output logic            burst_end
);

    // Narrow beats left after the current one
    logic [7:0] remaining;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            lane      <= '0;
            remaining <= '0;
        end else if (load) begin
            lane      <= start_lane;
            remaining <= narrow_len;
        end else if (beat_taken) begin
            lane <= (lane == lane_t'(ratio - 1)) ? '0 : lane + 1'b1;
            if (!burst_end) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    assign burst_end = (remaining == '0);

    // Wide beat is used up at the top lane or at the end of the burst
    assign lane_end = (lane == lane_t'(ratio - 1)) || burst_end;

endmodule

`default_nettype wire

/* beat_splitter.sv */
// Holds one wide R beat and hands it out one narrow lane at a time
// Lane and last come from the beat counter

`default_nettype none

module beat_splitter
    import rd_pkg::*;
(
    input  wire logic    aclk,
    input  wire logic    rst_n,
    input  wire logic    active,

    // Wide R from the master port
    input  wire r_wide_t m_r,
    input  wire logic    m_rvalid,
    output logic         m_rready,

    // Beat counter status
    input  wire lane_t   lane,
    input  wire logic    lane_end,
    input  wire logic    burst_end,
    output logic         beat_taken,

    // Narrow R toward the skid buffer
    output r_narrow_t    n_r,
    output logic         n_valid,
    input  wire logic    n_ready
);

    r_wide_t held_beat;
    logic    held;
    logic    release_beat;

    assign n_valid      = held && active;
    assign beat_taken   = n_valid && n_ready;
    assign release_beat = beat_taken && lane_end;

    // Room for a new wide beat once the held one is about to go
    assign m_rready = !held || release_beat;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (m_rvalid && m_rready) begin
            held <= 1'b1;
        end else if (release_beat) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (m_rvalid && m_rready) begin
            held_beat <= m_r;
        end
    end

    // ID and response repeat on every narrow beat
    assign n_r.id   = held_beat.id;
    assign n_r.data = held_beat.data[lane * s_data_w +: s_data_w];
    assign n_r.resp = held_beat.resp;
    assign n_r.last = burst_end;

endmodule

`default_nettype wire

/* burst_fsm.sv */
// Burst control for the upsizer core
// Takes one narrow AR, issues the wide AR and waits for the burst to drain

`default_nettype none

module burst_fsm
    import rd_pkg::*;
(
    input  wire logic aclk,
    input  wire logic rst_n,

    // Narrow AR from the skid buffer
    input  wire logic ar_valid,
    output logic      ar_ready,
    input  wire ar_t  ar,

    // Wide AR to the master port
    output ar_t       m_ar,
    output logic      m_arvalid,
    input  wire logic m_arready,

    // Beat counter control
    output logic       load,
    output lane_t      start_lane,
    output logic [7:0] narrow_len,
    input  wire logic  burst_end,
    input  wire logic  beat_taken,

    output logic      active
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t            state;
    logic              take;
    logic [8:0]        span;
    logic [addr_w-1:0] aligned_addr;

    // ============================================================
    // Address translation
    // ============================================================

    assign start_lane = ar.addr[s_off_w +: lane_w];
    assign narrow_len = ar.len;

    // Last narrow beat position counted in lanes from the wide boundary
    assign span = {1'b0, ar.len} + 9'(start_lane);

    always_comb begin
        aligned_addr = ar.addr;
        aligned_addr[m_off_w-1:0] = '0;
    end

    assign ar_ready = (state == st_idle);
    assign take     = ar_valid && ar_ready;
    assign load     = take;

    // Captured once per burst, held while m_arvalid waits
    always_ff @(posedge aclk) begin
        if (take) begin
            m_ar.id    <= ar.id;
            m_ar.addr  <= aligned_addr;
            m_ar.len   <= 8'(span >> lane_w);
            m_ar.size  <= m_size;
            m_ar.burst <= ar.burst;
            m_ar.cache <= ar.cache;
            m_ar.prot  <= ar.prot;
        end
    end

    // ============================================================
    // State machine
    // ============================================================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (m_arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    // Final narrow beat leaves the splitter
                    if (beat_taken && burst_end) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign m_arvalid = (state == st_addr);
    assign active    = (state != st_idle);

endmodule

`default_nettype wire

/* rd_cfg.svh */
// Width and depth settings for the AXI4 read upsizer
// Included by the package and by the testbench

`ifndef RD_CFG_SVH
`define RD_CFG_SVH

// ============================================================
// Data widths
// ============================================================

// Narrow slave port
`define RD_S_DATA_W 32

// Wide master port
`define RD_M_DATA_W 128

// ============================================================
// Address and ID
// ============================================================

`define RD_ID_W 4
`define RD_ADDR_W 32

// ============================================================
// Skid buffer depths
// ============================================================

`define RD_AR_DEPTH 2
`define RD_R_DEPTH 4

`endif

/* rd_pkg.sv */
// Payload types and derived constants shared by all upsizer modules
// Modules pull these in with a wildcard import

`default_nettype none

`include "rd_cfg.svh"

package rd_pkg;

    // ============================================================
    // Widths
    // ============================================================

    localparam int s_data_w = `RD_S_DATA_W;
    localparam int m_data_w = `RD_M_DATA_W;
    localparam int id_w     = `RD_ID_W;
    localparam int addr_w   = `RD_ADDR_W;

    // Narrow lanes per wide beat
    localparam int ratio  = m_data_w / s_data_w;
    localparam int lane_w = $clog2(ratio);

    // Byte offset bits within a narrow and a wide beat
    localparam int s_off_w = $clog2(s_data_w / 8);
    localparam int m_off_w = $clog2(m_data_w / 8);

    // AXI size code of the wide beat
    localparam logic [2:0] m_size = 3'(m_off_w);

    typedef logic [lane_w-1:0] lane_t;

    // ============================================================
    // Channel payloads
    // ============================================================

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } ar_t;

    // Slave side R beat
    typedef struct packed {
        logic [id_w-1:0]     id;
        logic [s_data_w-1:0] data;
        logic [1:0]          resp;
        logic                last;
    } r_narrow_t;

    // Master side R beat
    typedef struct packed {
        logic [id_w-1:0]     id;
        logic [m_data_w-1:0] data;
        logic [1:0]          resp;
        logic                last;
    } r_wide_t;

endpackage

`default_nettype wire

/* rd_stimulus.txt */
# id(hex) addr(hex) narrow_len(dec) slverr(0/1) expected_master_arlen(dec)
# one read burst per line, issued back to back in file order
1 00001000 0 0 0
2 00001004 0 0 0
3 0000100c 1 0 1
4 00002000 3 0 0
5 00002008 3 1 1
6 00002010 7 0 1
7 00002014 7 0 2
8 0000301c 15 0 4
9 00003100 31 1 7
a 00003204 2 0 0
b 00003208 2 0 1
c 0000400c 0 1 0
d 00004020 63 0 15
e 00004124 20 0 5
f 00005008 9 1 2
0 0000500c 4 0 1
1 00006000 255 0 63
2 00006402 5 0 1
3 00006ffc 0 0 0
4 00007018 12 1 3
5 00007030 1 0 0
6 00007038 6 0 2

/* rd_upsize_top.sv */
// AXI4 read path upsizer, 32-bit slave port onto a 128-bit master port
// Skid buffers on AR and R around a single-burst converter core

`default_nettype none

`include "rd_cfg.svh"

module rd_upsize_top
    import rd_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst_n,

    // ============================================================
    // Slave side
    // ============================================================

    input  wire ar_t       s_ar,
    input  wire logic      s_arvalid,
    output logic           s_arready,
    output r_narrow_t      s_r,
    output logic           s_rvalid,
    input  wire logic      s_rready,

    // ============================================================
    // Master side
    // ============================================================

    output ar_t            m_ar,
    output logic           m_arvalid,
    input  wire logic      m_arready,
    input  wire r_wide_t   m_r,
    input  wire logic      m_rvalid,
    output logic           m_rready
);

    // AR skid output into the core
    ar_t        core_ar;
    logic       core_arvalid;
    logic       core_arready;

    // Core control
    logic       load;
    lane_t      start_lane;
    logic [7:0] narrow_len;
    lane_t      lane;
    logic       lane_end;
    logic       burst_end;
    logic       beat_taken;
    logic       active;

    // Narrow R into the R skid
    r_narrow_t  n_r;
    logic       n_valid;
    logic       n_ready;

    skid_buffer #(
        .payload_t (ar_t),
        .depth     (`RD_AR_DEPTH)
    ) ar_skid_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (s_arvalid),
        .in_ready  (s_arready),
        .in_data   (s_ar),
        .out_valid (core_arvalid),
        .out_ready (core_arready),
        .out_data  (core_ar)
    );

    burst_fsm burst_fsm_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .ar_valid   (core_arvalid),
        .ar_ready   (core_arready),
        .ar         (core_ar),
        .m_ar       (m_ar),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .load       (load),
        .start_lane (start_lane),
        .narrow_len (narrow_len),
        .burst_end  (burst_end),
        .beat_taken (beat_taken),
        .active     (active)
    );

    beat_counter beat_counter_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .load       (load),
        .start_lane (start_lane),
        .narrow_len (narrow_len),
        .beat_taken (beat_taken),
        .lane       (lane),
        .lane_end   (lane_end),
        .burst_end  (burst_end)
    );

    beat_splitter beat_splitter_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .active     (active),
        .m_r        (m_r),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .lane       (lane),
        .lane_end   (lane_end),
        .burst_end  (burst_end),
        .beat_taken (beat_taken),
        .n_r        (n_r),
        .n_valid    (n_valid),
        .n_ready    (n_ready)
    );

    skid_buffer #(
        .payload_t (r_narrow_t),
        .depth     (`RD_R_DEPTH)
    ) r_skid_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (n_valid),
        .in_ready  (n_ready),
        .in_data   (n_r),
        .out_valid (s_rvalid),
        .out_ready (s_rready),
        .out_data  (s_r)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the read upsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_rd_upsize -f sources.f -o tb_rd_upsize > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rd_upsize > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "All tests passed" "$SIM_LOG"; then
    echo "simulation log has no final result"
    exit 1
fi
exit 0

/* skid_buffer.sv */
// Small valid/ready FIFO used to break timing on a channel
// Payload type and depth are set per instance

`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire logic     aclk,
    input  wire logic     rst_n,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               push;
    logic               pop;

    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
rd_pkg.sv
skid_buffer.sv
burst_fsm.sv
beat_counter.sv
beat_splitter.sv
rd_upsize_top.sv
tb_rd_upsize.sv

/* tb_rd_upsize.sv */
// Testbench for the AXI4 read upsizer
// Replays the requests in rd_stimulus.txt against a wide memory model
// with random back-pressure on slave R, master AR and master R

`default_nettype none

`include "rd_cfg.svh"

module tb_rd_upsize
    import rd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_reqs      = 64;
    localparam int ar_timeout    = 4000;
    localparam int drain_timeout = 20000;

    // Burst as seen by the memory model on the master AR channel
    typedef struct packed {
        logic [`RD_ADDR_W-1:0] addr;
        logic [8:0]            beats;
        logic [`RD_ID_W-1:0]   id;
        logic                  err;
    } burst_t;

    logic      aclk;
    logic      rst_n;
    ar_t       s_ar;
    logic      s_arvalid;
    logic      s_arready;
    r_narrow_t s_r;
    logic      s_rvalid;
    logic      s_rready;
    ar_t       m_ar;
    logic      m_arvalid;
    logic      m_arready;
    r_wide_t   m_r;
    logic      m_rvalid;
    logic      m_rready;

    // Requests from the stimulus file
    logic [`RD_ID_W-1:0]   req_id   [max_reqs];
    logic [`RD_ADDR_W-1:0] req_addr [max_reqs];
    int                    req_len  [max_reqs];
    int                    req_err  [max_reqs];
    int                    req_mlen [max_reqs];
    int                    num_reqs;

    ar_t       exp_ar_q [$];
    logic      exp_err_q [$];
    r_narrow_t exp_r_q [$];
    burst_t    bursts [max_reqs];

    // Monitor counters updated on the rising edge only
    int ar_hs_count   = 0;
    int mar_count     = 0;
    int mr_hs_count   = 0;
    int beats_checked = 0;
    int check_errors  = 0;

    int          main_errors;
    logic        timed_out;
    logic        bp_en;
    logic [31:0] lfsr_state;

    rd_upsize_top rd_upsize_top_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #50 aclk = ~aclk;
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // Memory content holds the ID in the top bits and the byte address below
    function automatic logic [31:0] lane_word(input logic [`RD_ID_W-1:0] id,
                                              input logic [31:0] byte_addr);
        return {id, byte_addr[`RD_S_DATA_W-`RD_ID_W-1:0]};
    endfunction

    function automatic r_wide_t wide_beat(input burst_t b, input int idx);
        r_wide_t     w;
        logic [31:0] base;
        int          j;
        base   = b.addr + 32'(idx * (m_data_w / 8));
        w.id   = b.id;
        w.data = '0;
        for (j = 0; j < ratio; j++) begin
            w.data[j * s_data_w +: s_data_w] = lane_word(b.id, base + 32'(j * 4));
        end
        w.resp = b.err ? 2'b10 : 2'b00;
        w.last = (idx == int'(b.beats) - 1);
        return w;
    endfunction

    function automatic logic same_value(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] id_v;
        logic [31:0] addr_v;
        int          len_v;
        int          err_v;
        int          mlen_v;
        fd = $fopen("rd_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file rd_stimulus.txt");
            main_errors++;
            return;
        end
        while (!$feof(fd) && num_reqs < max_reqs) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            // Lines starting with # describe the columns
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %d %d %d", id_v, addr_v, len_v, err_v, mlen_v);
                if (n == 5) begin
                    req_id[num_reqs]   = id_v[`RD_ID_W-1:0];
                    req_addr[num_reqs] = addr_v;
                    req_len[num_reqs]  = len_v;
                    req_err[num_reqs]  = err_v;
                    req_mlen[num_reqs] = mlen_v;
                    num_reqs++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Expected master AR and narrow beats for request i
    task automatic record_request(input int i);
        ar_t         e;
        r_narrow_t   b;
        logic [31:0] a;
        int          k;
        e.id    = req_id[i];
        e.addr  = req_addr[i] & ~32'hF;
        e.len   = 8'(req_mlen[i]);
        e.size  = 3'd4;
        e.burst = 2'b01;
        e.cache = 4'(i);
        e.prot  = 3'(i);
        exp_ar_q.push_back(e);
        exp_err_q.push_back(req_err[i] != 0);
        a = req_addr[i] & ~32'h3;
        for (k = 0; k <= req_len[i]; k++) begin
            b.id   = req_id[i];
            b.data = lane_word(req_id[i], a + 32'(k * 4));
            b.resp = (req_err[i] != 0) ? 2'b10 : 2'b00;
            b.last = (k == req_len[i]);
            exp_r_q.push_back(b);
        end
    endtask

    task automatic check_master_ar();
        ar_t    e;
        burst_t b;
        if (exp_ar_q.size() == 0) begin
            $display("master AR issued at %0d ns with no request outstanding", $time);
            check_errors++;
            return;
        end
        e = exp_ar_q.pop_front();
        if (!same_value("m_ar.id", 32'(m_ar.id), 32'(e.id))) check_errors++;
        if (!same_value("m_ar.addr", m_ar.addr, e.addr)) check_errors++;
        if (!same_value("m_ar.len", 32'(m_ar.len), 32'(e.len))) check_errors++;
        if (!same_value("m_ar.size", 32'(m_ar.size), 32'(e.size))) check_errors++;
        if (!same_value("m_ar.burst", 32'(m_ar.burst), 32'(e.burst))) check_errors++;
        if (!same_value("m_ar.cache", 32'(m_ar.cache), 32'(e.cache))) check_errors++;
        if (!same_value("m_ar.prot", 32'(m_ar.prot), 32'(e.prot))) check_errors++;
        b.addr  = m_ar.addr;
        b.beats = 9'(m_ar.len) + 9'd1;
        b.id    = m_ar.id;
        b.err   = exp_err_q.pop_front();
        if (mar_count < max_reqs) begin
            bursts[mar_count] = b;
        end
        mar_count++;
    endtask

    task automatic check_narrow_beat();
        r_narrow_t e;
        if (exp_r_q.size() == 0) begin
            $display("slave R beat at %0d ns arrived with no beat expected", $time);
            check_errors++;
            return;
        end
        e = exp_r_q.pop_front();
        if (!same_value("s_r.id", 32'(s_r.id), 32'(e.id))) check_errors++;
        if (!same_value("s_r.data", s_r.data, e.data)) check_errors++;
        if (!same_value("s_r.resp", 32'(s_r.resp), 32'(e.resp))) check_errors++;
        if (!same_value("s_r.last", 32'(s_r.last), 32'(e.last))) check_errors++;
        beats_checked++;
    endtask

    task automatic issue_requests();
        int i;
        int wait_cycles;
        for (i = 0; i < num_reqs; i++) begin
            s_ar.id    = req_id[i];
            s_ar.addr  = req_addr[i];
            s_ar.len   = 8'(req_len[i]);
            s_ar.size  = 3'd2;
            s_ar.burst = 2'b01;
            s_ar.cache = 4'(i);
            s_ar.prot  = 3'(i);
            s_arvalid  = 1'b1;
            wait_cycles = 0;
            while (ar_hs_count <= i && wait_cycles < ar_timeout) begin
                @(negedge aclk);
                wait_cycles++;
            end
            if (ar_hs_count <= i) begin
                $display("timeout: s_arready never accepted request %0d", i);
                main_errors++;
                timed_out = 1'b1;
                break;
            end
        end
        s_arvalid = 1'b0;
    endtask

    // ============================================================
    // Monitor on the rising edge
    // ============================================================

    always @(posedge aclk) begin
        if (rst_n) begin
            if (s_arvalid && s_arready) begin
                record_request(ar_hs_count);
                ar_hs_count++;
            end
            if (m_arvalid && m_arready) begin
                check_master_ar();
            end
            if (m_rvalid && m_rready) begin
                mr_hs_count++;
            end
            if (s_rvalid && s_rready) begin
                check_narrow_beat();
            end
        end
    end

    // ============================================================
    // Memory model and back-pressure driven on the falling edge
    // ============================================================

    initial begin : memory_model
        burst_t cur_burst;
        logic   serving;
        logic   r0;
        logic   r1;
        int     beat_idx;
        int     burst_idx;
        int     served;
        s_rready   = 1'b0;
        m_arready  = 1'b0;
        m_rvalid   = 1'b0;
        m_r        = '0;
        lfsr_state = 32'h0950_ed15;
        cur_burst  = '0;
        serving    = 1'b0;
        beat_idx   = 0;
        burst_idx  = 0;
        served     = 0;
        forever begin
            @(negedge aclk);
            if (bp_en) begin
                r0 = rand_bit();
                r1 = rand_bit();
                s_rready  = r0 | r1;
                m_arready = rand_bit();
                // Wide beat taken on the last rising edge
                if (mr_hs_count != served) begin
                    served++;
                    m_rvalid = 1'b0;
                    beat_idx++;
                    if (beat_idx == int'(cur_burst.beats)) begin
                        serving = 1'b0;
                    end
                end
                if (!serving && burst_idx < mar_count) begin
                    cur_burst = bursts[burst_idx];
                    burst_idx++;
                    serving   = 1'b1;
                    beat_idx  = 0;
                end
                if (serving && !m_rvalid) begin
                    r0 = rand_bit();
                    if (r0) begin
                        m_r      = wide_beat(cur_burst, beat_idx);
                        m_rvalid = 1'b1;
                    end
                end
            end
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin : main_sequence
        int wait_cycles;
        int total_beats;
        int i;
        rst_n       = 1'b0;
        s_ar        = '0;
        s_arvalid   = 1'b0;
        bp_en       = 1'b0;
        main_errors = 0;
        timed_out   = 1'b0;
        num_reqs    = 0;
        total_beats = 0;
        load_stimulus();
        for (i = 0; i < num_reqs; i++) begin
            total_beats += req_len[i] + 1;
        end
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        // Idle outputs before any request
        for (i = 0; i < 5; i++) begin
            @(negedge aclk);
            if (!same_value("s_rvalid", 32'(s_rvalid), 32'd0)) main_errors++;
            if (!same_value("m_arvalid", 32'(m_arvalid), 32'd0)) main_errors++;
            if (!same_value("s_arready", 32'(s_arready), 32'd1)) main_errors++;
            // No wide beat held yet
            if (!same_value("m_rready", 32'(m_rready), 32'd1)) main_errors++;
        end

        @(posedge aclk);
        bp_en = 1'b1;
        @(negedge aclk);
        issue_requests();

        if (!timed_out) begin
            wait_cycles = 0;
            while (beats_checked < total_beats && wait_cycles < drain_timeout) begin
                @(negedge aclk);
                wait_cycles++;
            end
            if (beats_checked < total_beats) begin
                $display("timeout: only %0d of %0d slave R beats arrived",
                         beats_checked, total_beats);
                main_errors++;
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            // Quiet period to catch extra beats
            repeat (20) @(negedge aclk);
            if (!same_value("master AR count", 32'(mar_count), 32'(num_reqs))) main_errors++;
        end

        $display("requests %0d, beats checked %0d, check errors %0d, other errors %0d",
                 num_reqs, beats_checked, check_errors, main_errors);
        if (check_errors == 0 && main_errors == 0 && num_reqs > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
